/* nes_joy_params.svh */
//////////////////////////////
// widths and timing constants
// for the joypad and reset glue
//////////////////////////////

`ifndef NES_JOY_PARAMS_SVH
`define NES_JOY_PARAMS_SVH

// snes layout button word
`define NJ_BTN_W    12

// bits per nes standard controller
`define NJ_NES_BITS 8

// autofire half period in clk cycles
// short value so a sim sees many toggles
// where hardware wants something near 1/30 s
`define NJ_AF_HALF  16

`endif

/* nes_joy_pkg.sv */
//////////////////////////////
// shared types for joypad glue
// button words, turbo pulses,
// console reset states
//////////////////////////////

`default_nettype none

package nes_joy_pkg;

    // snes layout (R L X A RT LT DN UP START SELECT Y B)
    // low byte is the nes controller byte and a goes out first
    typedef struct packed {
        logic r;
        logic l;
        logic turbo_b;   // snes X, autofire b
        logic turbo_a;   // snes A, autofire a
        logic right;
        logic left;
        logic down;
        logic up;
        logic start;
        logic select;
        logic b;
        logic a;
    } joy_btns_t;

    typedef struct packed {
        joy_btns_t p1;
        joy_btns_t p2;
    } joy_pair_t;

    // one autofire pulse per turbo button
    typedef struct packed {
        logic a1;
        logic b1;
        logic a2;
        logic b2;
    } turbo_t;

    typedef enum logic [1:0] {
        RST_HOLD = 2'd0,   // held until a rom arrives
        RST_LOAD = 2'd1,   // rom streaming in
        RST_RUN  = 2'd2    // console running
    } nes_rst_state_t;

endpackage

`default_nettype wire

/* autofire_gen.sv */
//////////////////////////////
// autofire pulse generators
// a/b turbo for both players
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "nes_joy_params.svh"

module autofire_gen (
    input  logic                   clk,
    input  logic                   sys_resetn,
    input  nes_joy_pkg::joy_pair_t buttons,
    output nes_joy_pkg::turbo_t    turbo
);
    import nes_joy_pkg::*;

    localparam int NCH   = 4;                      // a1 b1 a2 b2
    localparam int CNT_W = $clog2(`NJ_AF_HALF);

    logic [NCH-1:0]   held;       // turbo buttons in turbo_t order
    logic [NCH-1:0]   pulse;
    logic [CNT_W-1:0] cnt [NCH];  // cycles left in this half period

    assign held = {buttons.p1.turbo_a, buttons.p1.turbo_b,
                   buttons.p2.turbo_a, buttons.p2.turbo_b};

    //////////////////////////////
    // half period down counters
    //////////////////////////////
    // a zero count while held means toggle now, so the first
    // held edge raises the pulse straight away
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            pulse <= '0;
            for (int i = 0; i < NCH; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NCH; i++) begin
                if (!held[i]) begin
                    pulse[i] <= 1'b0;          // released so park low
                    cnt[i]   <= '0;
                end else if (cnt[i] == '0) begin
                    pulse[i] <= ~pulse[i];
                    cnt[i]   <= CNT_W'(`NJ_AF_HALF - 1);  // reload
                end else begin
                    cnt[i] <= cnt[i] - 1'b1;
                end
            end
        end
    end

    assign turbo = turbo_t'(pulse);

endmodule

`default_nettype wire

/* nes_reset_ctrl.sv */
//////////////////////////////
// console reset sequencing
// load edges and home combo
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nes_reset_ctrl (
    input  logic clk,
    input  logic sys_resetn,
    input  logic loading,
    input  logic home_combo,    // p1 select + down
    output logic nes_reset
);
    import nes_joy_pkg::*;

    nes_rst_state_t state;
    nes_rst_state_t state_nxt;

    logic loading_q;        // last sampled loading
    logic load_rise;
    logic load_fall;

    assign load_rise = loading & ~loading_q;
    assign load_fall = ~loading & loading_q;

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            loading_q <= 1'b0;
            state     <= RST_HOLD;
        end else begin
            loading_q <= loading;
            state     <= state_nxt;
        end
    end

    //////////////////////////////
    // next state
    //////////////////////////////
    always_comb begin
        state_nxt = state;
        case (state)
            RST_HOLD: if (load_rise) state_nxt = RST_LOAD;
            RST_LOAD: if (load_fall) state_nxt = RST_RUN;    // rom is in so let it go
            RST_RUN: begin
                if (load_rise)
                    state_nxt = RST_LOAD;           // new rom while running
                else if (home_combo)
                    state_nxt = RST_HOLD;           // back to reset until next load
            end
            default: state_nxt = RST_HOLD;
        endcase
    end

    // console only runs in RST_RUN
    assign nes_reset = (state != RST_RUN);

endmodule

`default_nettype wire

/* joypad_shifter.sv */
//////////////////////////////
// nes controller shift regs
// two ports, autofire merged in
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "nes_joy_params.svh"

module joypad_shifter (
    input  logic                   clk,
    input  logic                   sys_resetn,
    input  logic                   nes_reset,
    input  nes_joy_pkg::joy_pair_t buttons,
    input  nes_joy_pkg::turbo_t    turbo,
    input  logic                   joypad_strobe,
    input  logic [1:0]             joypad_clock,
    output logic [1:0]             joypad_data
);
    import nes_joy_pkg::*;

    localparam int NB = `NJ_NES_BITS;

    logic [NB-1:0] bits [2];       // per port shift register
    logic [NB-1:0] load_val [2];   // merged byte to latch on strobe
    logic [1:0]    clk_q;          // last joypad_clock
    logic [1:0]    clk_fall;

    // nes byte with turbo pulses folded onto a and b
    function automatic logic [NB-1:0] merge_byte(input joy_btns_t btn,
                                                 input logic ta,
                                                 input logic tb);
        logic [NB-1:0] nes;
        nes    = btn[NB-1:0];
        nes[0] = btn.a | ta;
        nes[1] = btn.b | tb;
        return nes;
    endfunction

    assign load_val[0] = merge_byte(buttons.p1, turbo.a1, turbo.b1);
    assign load_val[1] = merge_byte(buttons.p2, turbo.a2, turbo.b2);

    assign clk_fall = clk_q & ~joypad_clock;

    //////////////////////////////
    // load / shift
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            clk_q <= '0;
            for (int p = 0; p < 2; p++) begin
                bits[p] <= '1;
            end
        end else begin
            clk_q <= joypad_clock;
            for (int p = 0; p < 2; p++) begin
                if (nes_reset)
                    bits[p] <= '1;                  // idle high while console held
                else if (joypad_strobe)
                    bits[p] <= load_val[p];         // strobe wins over a shift
                else if (clk_fall[p])
                    bits[p] <= {1'b1, bits[p][NB-1:1]};  // ones after 8 reads
            end
        end
    end

    assign joypad_data = {bits[1][0], bits[0][0]};

endmodule

`default_nettype wire

/* nes_joy_top.sv */
//////////////////////////////
// joypad and console reset glue
// autofire, reset fsm, shifters
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nes_joy_top (
    input  logic                   clk,
    input  logic                   sys_resetn,
    input  logic                   loading,        // high while rom streams
    input  logic                   joypad_strobe,  // from console
    input  nes_joy_pkg::joy_pair_t buttons,
    input  logic [1:0]             joypad_clock,   // per port
    output logic                   nes_reset,
    output logic [1:0]             joypad_data
);
    import nes_joy_pkg::*;

    turbo_t turbo;
    logic   home_combo;

    // pad home button shows up as select + down
    assign home_combo = buttons.p1.select & buttons.p1.down;

    autofire_gen u_autofire (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .buttons    (buttons),
        .turbo      (turbo)
    );

    nes_reset_ctrl u_reset_ctrl (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .loading    (loading),
        .home_combo (home_combo),
        .nes_reset  (nes_reset)
    );

    joypad_shifter u_shifter (
        .clk           (clk),
        .sys_resetn    (sys_resetn),
        .nes_reset     (nes_reset),
        .buttons       (buttons),
        .turbo         (turbo),
        .joypad_strobe (joypad_strobe),
        .joypad_clock  (joypad_clock),
        .joypad_data   (joypad_data)
    );

endmodule

`default_nettype wire

/* nes_joy_sva.sv */
//////////////////////////////
// assertions on the joypad top
// reset, idle data, turbo release
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module nes_joy_sva (
    input logic                   clk,
    input logic                   sys_resetn,
    input logic                   nes_reset,
    input logic [1:0]             joypad_data,
    input nes_joy_pkg::joy_pair_t buttons,
    input nes_joy_pkg::turbo_t    turbo
);
    import nes_joy_pkg::*;

    logic [3:0] held;   // turbo_t order
    logic [3:0] pulse;

    assign held  = {buttons.p1.turbo_a, buttons.p1.turbo_b,
                    buttons.p2.turbo_a, buttons.p2.turbo_b};
    assign pulse = turbo;

    // console held while system reset
    a_reset_follows: assert property (@(posedge clk) !sys_resetn |=> nes_reset)
        else $error("nes_reset low after system reset");

    // registers idle high one edge into console reset
    a_idle_ones: assert property (@(posedge clk) disable iff (!sys_resetn)
        nes_reset |=> joypad_data == 2'b11)
        else $error("joypad_data not all ones during console reset");

    // release parks the pulse low
    a_turbo_off: assert property (@(posedge clk) disable iff (!sys_resetn)
        1'b1 |=> ((pulse & ~$past(held)) == 4'b0))
        else $error("turbo pulse high after release");

endmodule

bind nes_joy_top nes_joy_sva u_sva (.*);

`default_nettype wire

/* tb_nes_joy.sv */
//////////////////////////////
// testbench for nes_joy_top
// reset, serial reads, autofire
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "nes_joy_params.svh"

module tb_nes_joy;
    import nes_joy_pkg::*;

    localparam int MAX_CYC = 4000;   // tests run about 1100

    logic clk = 1'b0;
    logic sys_resetn;
    logic loading;
    logic joypad_strobe;
    joy_pair_t buttons;
    logic [1:0] joypad_clock;
    logic nes_reset;
    logic [1:0] joypad_data;

    logic [31:0] rng = 32'd16;
    int cyc = 0;

    // model state
    logic [3:0] m_pulse;
    int m_cnt [4];
    nes_rst_state_t m_state;
    logic m_loading_q;

    nes_joy_top dut (.*);

    always #4 clk = ~clk;

    //////////////////////////////
    // reference functions
    //////////////////////////////
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] v;
        v = x;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // nes byte with a at bit 0 and turbo ored in
    function automatic logic [7:0] ref_byte(input joy_btns_t b, input logic ta, input logic tb);
        return {b.right, b.left, b.down, b.up, b.start, b.select, b.b | tb, b.a | ta};
    endfunction

    function automatic nes_rst_state_t ref_rst(input nes_rst_state_t s, input logic ld,
                                               input logic ld_q, input logic combo);
        if (ld && !ld_q && s != RST_LOAD)
            return RST_LOAD;                        // load starts
        if (s == RST_LOAD && !ld && ld_q)
            return RST_RUN;                         // load ended
        if (s == RST_RUN && combo)
            return RST_HOLD;
        return s;
    endfunction

    // autofire and reset models on the dut clock edge
    always @(posedge clk) begin
        logic [3:0] h;
        h = {buttons.p1.turbo_a, buttons.p1.turbo_b, buttons.p2.turbo_a, buttons.p2.turbo_b};
        if (!sys_resetn) begin
            m_pulse     <= '0;
            m_state     <= RST_HOLD;
            m_loading_q <= 1'b0;
            for (int i = 0; i < 4; i++) begin
                m_cnt[i] <= 0;
            end
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (!h[i]) begin
                    m_pulse[i] <= 1'b0;
                    m_cnt[i]   <= 0;
                end else if (m_cnt[i] == 0) begin
                    m_pulse[i] <= ~m_pulse[i];      // toggle and start a new half period
                    m_cnt[i]   <= `NJ_AF_HALF - 1;
                end else begin
                    m_cnt[i] <= m_cnt[i] - 1;
                end
            end
            m_state     <= ref_rst(m_state, loading, m_loading_q,
                                   buttons.p1.select & buttons.p1.down);
            m_loading_q <= loading;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////
    task automatic check_nes_byte(input string name, input logic [7:0] exp,
                                  input logic [7:0] act);
        if (act !== exp) begin
            $display("error %s expected %02h actual %02h", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "mismatch");
        end
    endtask

    task automatic check_reset(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s expected %b actual %b", name, exp, act);
            $display("** FAIL **");
            $fatal(1, "mismatch");
        end
    endtask

    // nes_reset against the model every cycle
    always @(negedge clk) begin
        if (sys_resetn)
            check_reset("reset_model", m_state != RST_RUN, nes_reset);
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= MAX_CYC) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYC);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // strobe then ten clock falls on both ports
    task automatic read_frame(input string name, input logic [7:0] exp1,
                              input logic [7:0] exp2, input logic use_turbo);
        logic [9:0] s1;
        logic [9:0] s2;
        logic [3:0] tq;
        logic [7:0] e1;
        logic [7:0] e2;
        tq = m_pulse;                       // pulse value seen at the load edge
        joypad_strobe = 1'b1;
        step();
        joypad_strobe = 1'b0;
        for (int i = 0; i < 10; i++) begin
            s1[i] = joypad_data[0];
            s2[i] = joypad_data[1];
            joypad_clock = 2'b11;
            step();
            joypad_clock = 2'b00;
            step();
        end
        e1 = exp1;
        e2 = exp2;
        if (use_turbo) begin
            e1 = ref_byte(buttons.p1, tq[3], tq[2]);
            e2 = ref_byte(buttons.p2, tq[1], tq[0]);
        end
        check_nes_byte({name, "_p1"}, e1, s1[7:0]);
        check_nes_byte({name, "_p2"}, e2, s2[7:0]);
        check_reset({name, "_p1_past8"}, 1'b1, &s1[9:8]);
        check_reset({name, "_p2_past8"}, 1'b1, &s2[9:8]);
    endtask

    task automatic load_pulse();
        loading = 1'b1;
        repeat (6) begin
            step();
            check_reset("during_load", 1'b1, nes_reset);
        end
        loading = 1'b0;
        step();
        check_reset("after_load", 1'b0, nes_reset);
    endtask

    task automatic rand_buttons();
        rng = xorshift(rng);
        buttons = joy_pair_t'(rng[23:0]);
        buttons.p1.turbo_a = 1'b0;
        buttons.p1.turbo_b = 1'b0;
        buttons.p2.turbo_a = 1'b0;
        buttons.p2.turbo_b = 1'b0;
        if (buttons.p1.select)
            buttons.p1.down = 1'b0;         // keep the home combo away
    endtask

    //////////////////////////////
    // tests
    //////////////////////////////
    initial begin
        sys_resetn    = 1'b0;
        loading       = 1'b0;
        joypad_strobe = 1'b0;
        buttons       = '0;
        joypad_clock  = 2'b00;
        repeat (16) @(posedge clk);
        #1 sys_resetn = 1'b1;
        step();

        // 1 after reset
        check_reset("reset_hold", 1'b1, nes_reset);
        check_reset("reset_data0", 1'b1, joypad_data[0]);
        check_reset("reset_data1", 1'b1, joypad_data[1]);

        // 2 loading pulse
        load_pulse();

        // 3 serial readout
        for (int f = 0; f < 20; f++) begin
            rand_buttons();
            step();
            read_frame("serial", ref_byte(buttons.p1, 1'b0, 1'b0),
                       ref_byte(buttons.p2, 1'b0, 1'b0), 1'b0);
        end

        // 4 autofire with a turbo on p1 and b turbo on p2 then swapped
        for (int ph = 0; ph < 2; ph++) begin
            rand_buttons();
            buttons.p1.a       = 1'b0;
            buttons.p1.b       = 1'b0;
            buttons.p2.a       = 1'b0;
            buttons.p2.b       = 1'b0;
            buttons.p1.turbo_a = (ph == 0);
            buttons.p1.turbo_b = (ph == 1);
            buttons.p2.turbo_a = (ph == 1);
            buttons.p2.turbo_b = (ph == 0);
            for (int f = 0; f < 12; f++) begin
                read_frame("autofire", 8'h00, 8'h00, 1'b1);
                repeat (f % 5) step();  // vary the phase
            end
            rand_buttons();             // release turbo
            repeat (3) step();
        end

        // 5 home combo
        buttons = '0;
        buttons.p1.select = 1'b1;
        buttons.p1.down   = 1'b1;
        step();
        check_reset("home_combo", 1'b1, nes_reset);
        buttons = '0;
        repeat (10) step();
        check_reset("home_stays", 1'b1, nes_reset);

        // 6 strobe ignored while held
        rand_buttons();
        read_frame("held_strobe", 8'hff, 8'hff, 1'b0);

        load_pulse();
        rand_buttons();
        step();
        read_frame("after_home", ref_byte(buttons.p1, 1'b0, 1'b0),
                   ref_byte(buttons.p2, 1'b0, 1'b0), 1'b0);

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
nes_joy_pkg.sv
autofire_gen.sv
nes_reset_ctrl.sv
joypad_shifter.sv
nes_joy_top.sv
nes_joy_sva.sv
tb_nes_joy.sv

/* run_sim.sh */
#!/bin/bash
# build and run the joypad glue testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f --top-module tb_nes_joy -o sim_nes_joy
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_nes_joy > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "\*\* PASS \*\*" "$LOG"; then
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi
